/* vtp_macros.svh */
/*
 * Widths and sizes for the translation shim.
 * VTP_HEAP_ENTRIES must be a power of two, since heap tags double as FIFO pointers.
 */

`ifndef VTP_MACROS_SVH
`define VTP_MACROS_SVH

// Cache-line address width
`define VTP_ADDR_BITS 42

// Line offset inside a 4KB page
`define VTP_OFFSET_BITS 6

// Direct-mapped TLB index width and entry count
`define VTP_CACHE_IDX_BITS 4
`define VTP_CACHE_ENTRIES (1 << `VTP_CACHE_IDX_BITS)

// Requests in flight, also the response FIFO depth
`define VTP_HEAP_ENTRIES 4

// User tag carried with each request
`define VTP_MDATA_BITS 16

`endif

/* vtp_pkg.sv */
/*
 * Types shared by the translation shim.
 * A page index is used for both virtual and physical pages.
 */

`include "vtp_macros.svh"

package vtp_pkg;

    // 4KB page index of a line address
    typedef logic [`VTP_ADDR_BITS-`VTP_OFFSET_BITS-1:0] vtp_page_t;

    // Heap tag, one per request in flight
    typedef logic [$clog2(`VTP_HEAP_ENTRIES)-1:0] vtp_heap_idx_t;

    typedef enum logic
    {
        op_read,
        op_write
    } vtp_opcode_e;

    // Memory request as seen on the channel
    typedef struct packed
    {
        vtp_opcode_e opcode;
        logic addr_is_virtual;
        logic [`VTP_ADDR_BITS-1:0] addr;
        logic [`VTP_MDATA_BITS-1:0] mdata;
    } vtp_req_t;

    // Lookup sent to the translation service
    typedef struct packed
    {
        vtp_page_t page_va;
        vtp_heap_idx_t tag;
    } vtp_lookup_req_t;

    // Service answer, matched to its request by tag
    typedef struct packed
    {
        vtp_page_t page_pa;
        vtp_heap_idx_t tag;
    } vtp_lookup_rsp_t;

endpackage

/* vtp_l1_tlb.sv */
/*
 * Direct-mapped L1 TLB for 4KB pages. A read returns hit and page two cycles later.
 * Reset and inval start a clear that walks one entry per cycle with rdy low.
 * A read during the walk may still see old entries.
 */

`timescale 1ns/1ns
`include "vtp_macros.svh"

module vtp_l1_tlb
(
    input  logic clk,
    input  logic reset,
    input  logic inval,
    output logic rdy,
    input  vtp_pkg::vtp_page_t rd_page,
    output logic rd_hit,
    output vtp_pkg::vtp_page_t rd_pa,
    input  logic wr_en,
    input  vtp_pkg::vtp_page_t wr_va,
    input  vtp_pkg::vtp_page_t wr_pa
);

    localparam int PAGE_BITS = $bits(vtp_pkg::vtp_page_t);
    localparam int IDX_BITS = `VTP_CACHE_IDX_BITS;
    localparam int TAG_BITS = PAGE_BITS - IDX_BITS;

    typedef logic [IDX_BITS-1:0] idx_t;
    typedef logic [TAG_BITS-1:0] tag_t;

    typedef struct packed
    {
        logic valid;
        tag_t tag;
        vtp_pkg::vtp_page_t pa;
    } entry_t;

    typedef enum logic
    {
        tlb_clear,
        tlb_ready
    } tlb_state_e;

    entry_t mem [0:`VTP_CACHE_ENTRIES-1];
    tlb_state_e state;
    idx_t clr_idx;
    logic [1:0] inval_d;
    entry_t rd_ent_q;
    tag_t rd_tag_q;

    // ==============================
    // Clear walk
    // ==============================

    // Invalidate is delayed two cycles before the walk starts
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            inval_d <= 2'b00;
        end
        else
        begin
            inval_d <= {inval_d[0], inval};
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset || inval_d[1])
        begin
            state <= tlb_clear;
            clr_idx <= '0;
        end
        else if (state == tlb_clear)
        begin
            clr_idx <= clr_idx + 1'b1;
            // Last index cleared
            if (clr_idx == '1)
                state <= tlb_ready;
        end
    end

    // Not ready while an invalidate is still on its way in
    assign rdy = (state == tlb_ready) && !(|inval_d);

    // ==============================
    // Storage
    // ==============================

    // Walk wins over a refill
    always_ff @(posedge clk)
    begin
        if (state == tlb_clear)
            mem[clr_idx] <= '0;
        else if (wr_en)
            mem[wr_va[IDX_BITS-1:0]] <= {1'b1, wr_va[PAGE_BITS-1:IDX_BITS], wr_pa};
    end

    // Cycle 1 holds the raw entry, cycle 2 the compared result
    always_ff @(posedge clk)
    begin
        rd_ent_q <= mem[rd_page[IDX_BITS-1:0]];
        rd_tag_q <= rd_page[PAGE_BITS-1:IDX_BITS];
        rd_hit <= rd_ent_q.valid && (rd_ent_q.tag == rd_tag_q);
        rd_pa <= rd_ent_q.pa;
    end

endmodule

/* vtp_req_heap.sv */
/*
 * Tag allocator and context store for requests in flight.
 * Caller must not allocate while not_full is low.
 * Context reads are combinational.
 */

`timescale 1ns/1ns
`include "vtp_macros.svh"

module vtp_req_heap
(
    input  logic clk,
    input  logic reset,
    input  logic alloc,
    output logic not_full,
    output vtp_pkg::vtp_heap_idx_t alloc_idx,
    input  logic wr_en,
    input  vtp_pkg::vtp_heap_idx_t wr_idx,
    input  vtp_pkg::vtp_req_t wr_req,
    input  vtp_pkg::vtp_heap_idx_t rd_idx,
    output vtp_pkg::vtp_req_t rd_req,
    input  logic free,
    input  vtp_pkg::vtp_heap_idx_t free_idx
);

    // One bit per tag, set when the tag is free
    logic [`VTP_HEAP_ENTRIES-1:0] free_map;

    vtp_pkg::vtp_req_t mem [0:`VTP_HEAP_ENTRIES-1];

    assign not_full = |free_map;

    // Lowest free tag goes out first
    always_comb
    begin
        alloc_idx = '0;
        for (int i = `VTP_HEAP_ENTRIES - 1; i >= 0; i--)
        begin
            if (free_map[i])
                alloc_idx = vtp_pkg::vtp_heap_idx_t'(i);
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            free_map <= '1;
        end
        else
        begin
            if (alloc)
                free_map[alloc_idx] <= 1'b0;
            // Freed tag never equals the one allocated this cycle
            if (free)
                free_map[free_idx] <= 1'b1;
        end
    end

    // Context held until the translation completes
    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_idx] <= wr_req;
    end

    assign rd_req = mem[rd_idx];

endmodule

/* vtp_chan.sv */
/*
 * Translation pipeline for one request channel.
 * Hits and passthroughs leave 4 cycles after acceptance, misses go to the service.
 * Service responses are merged into bubbles and refill the TLB.
 */

`timescale 1ns/1ns
`include "vtp_macros.svh"

module vtp_chan
(
    input  logic clk,
    input  logic reset,
    input  logic inval,
    output logic not_full,
    input  logic in_valid,
    input  vtp_pkg::vtp_req_t in_req,
    output logic out_valid,
    output vtp_pkg::vtp_req_t out_req,
    output vtp_pkg::vtp_page_t out_pa_page,
    input  logic out_almost_full,
    input  logic lookup_rdy,
    output logic lookup_en,
    output vtp_pkg::vtp_lookup_req_t lookup_req,
    input  logic lookup_rsp_valid,
    input  vtp_pkg::vtp_lookup_rsp_t lookup_rsp
);

    // Per-stage control carried down the pipe
    typedef struct packed
    {
        logic valid;
        vtp_pkg::vtp_page_t page;
        logic is_virtual;
        vtp_pkg::vtp_heap_idx_t tag;
    } stage_t;

    stage_t st0;
    stage_t st [1:3];

    logic tlb_rdy;
    logic tlb_hit;
    vtp_pkg::vtp_page_t tlb_pa;
    logic hit_q;
    vtp_pkg::vtp_page_t pa_q;
    logic tlb_wr_en;
    vtp_pkg::vtp_page_t tlb_wr_va;
    vtp_pkg::vtp_page_t tlb_wr_pa;

    logic heap_not_full;
    vtp_pkg::vtp_heap_idx_t alloc_idx;
    vtp_pkg::vtp_heap_idx_t read_idx;
    vtp_pkg::vtp_heap_idx_t free_idx;
    vtp_pkg::vtp_req_t heap_rd_req;
    logic not_full_reg;

    vtp_pkg::vtp_lookup_rsp_t fifo_mem [0:`VTP_HEAP_ENTRIES-1];
    vtp_pkg::vtp_heap_idx_t fifo_wr_ptr;
    vtp_pkg::vtp_heap_idx_t fifo_rd_ptr;
    logic [$clog2(`VTP_HEAP_ENTRIES+1)-1:0] fifo_count;
    logic fifo_not_empty;
    vtp_pkg::vtp_lookup_rsp_t fifo_head;
    vtp_pkg::vtp_lookup_rsp_t rsp_q;
    logic rsp_deq;
    logic rsp_deq_q;
    logic rsp_deq_qq;
    logic pick_main_path;

    // ==============================
    // Pipeline stages
    // ==============================

    // Stage 0 is the acceptance cycle
    assign st0.valid = in_valid;
    assign st0.page = in_req.addr[`VTP_ADDR_BITS-1:`VTP_OFFSET_BITS];
    assign st0.is_virtual = in_req.addr_is_virtual;
    assign st0.tag = alloc_idx;

    always_ff @(posedge clk)
    begin
        st[1] <= st0;
        st[2] <= st[1];
        st[3] <= st[2];
        if (reset)
        begin
            for (int s = 1; s <= 3; s++)
                st[s].valid <= 1'b0;
        end
    end

    // TLB read starts in stage 0, result arrives in stage 2
    vtp_l1_tlb tlb_inst
    (
        .clk(clk),
        .reset(reset),
        .inval(inval),
        .rdy(tlb_rdy),
        .rd_page(st0.page),
        .rd_hit(tlb_hit),
        .rd_pa(tlb_pa),
        .wr_en(tlb_wr_en),
        .wr_va(tlb_wr_va),
        .wr_pa(tlb_wr_pa)
    );

    // Hit decision is taken in stage 3
    always_ff @(posedge clk)
    begin
        hit_q <= tlb_hit;
        pa_q <= tlb_pa;
    end

    // Context written at acceptance, freed on completion
    vtp_req_heap heap_inst
    (
        .clk(clk),
        .reset(reset),
        .alloc(st0.valid),
        .not_full(heap_not_full),
        .alloc_idx(alloc_idx),
        .wr_en(st0.valid),
        .wr_idx(alloc_idx),
        .wr_req(in_req),
        .rd_idx(read_idx),
        .rd_req(heap_rd_req),
        .free(out_valid),
        .free_idx(free_idx)
    );

    // Slow terms registered, almost full stays direct
    always_ff @(posedge clk)
    begin
        if (reset)
            not_full_reg <= 1'b0;
        else
            not_full_reg <= lookup_rdy && tlb_rdy && !fifo_not_empty;
    end

    assign not_full = heap_not_full && not_full_reg && !out_almost_full;

    // ==============================
    // Service lookup and responses
    // ==============================

    // Miss goes out in stage 4
    always_ff @(posedge clk)
    begin
        if (reset)
            lookup_en <= 1'b0;
        else
            lookup_en <= st[3].valid && st[3].is_virtual && !hit_q;
        lookup_req.page_va <= st[3].page;
        lookup_req.tag <= st[3].tag;
    end

    // Response FIFO, never more entries than outstanding lookups
    assign fifo_not_empty = (fifo_count != '0);
    assign fifo_head = fifo_mem[fifo_rd_ptr];

    always_ff @(posedge clk)
    begin
        if (lookup_rsp_valid)
            fifo_mem[fifo_wr_ptr] <= lookup_rsp;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            fifo_wr_ptr <= '0;
            fifo_rd_ptr <= '0;
            fifo_count <= '0;
        end
        else
        begin
            if (lookup_rsp_valid)
                fifo_wr_ptr <= fifo_wr_ptr + 1'b1;
            if (rsp_deq)
                fifo_rd_ptr <= fifo_rd_ptr + 1'b1;
            case ({lookup_rsp_valid, rsp_deq})
                2'b10: fifo_count <= fifo_count + 1'b1;
                2'b01: fifo_count <= fifo_count - 1'b1;
                default: fifo_count <= fifo_count;
            endcase
        end
    end

    // Bubble seen in stage 2 leaves stage 3 free for the response
    assign rsp_deq = fifo_not_empty && !st[2].valid && !out_almost_full;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rsp_deq_q <= 1'b0;
            rsp_deq_qq <= 1'b0;
        end
        else
        begin
            rsp_deq_q <= rsp_deq;
            rsp_deq_qq <= rsp_deq_q;
        end
        rsp_q <= fifo_head;
    end

    // ==============================
    // Output merge
    // ==============================

    // Main path for passthroughs and hits
    assign pick_main_path = st[3].valid && (!st[3].is_virtual || hit_q);

    // Context index for the heap read in stage 3
    always_ff @(posedge clk)
    begin
        read_idx <= rsp_deq ? fifo_head.tag : st[2].tag;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            out_valid <= 1'b0;
        else
            out_valid <= pick_main_path || rsp_deq_q;
        out_req <= heap_rd_req;
        free_idx <= read_idx;
        out_pa_page <= pick_main_path ? pa_q : rsp_q.page_pa;
    end

    // Refill one cycle after the response leaves
    always_ff @(posedge clk)
    begin
        if (reset)
            tlb_wr_en <= 1'b0;
        else
            tlb_wr_en <= rsp_deq_qq;
        tlb_wr_va <= out_req.addr[`VTP_ADDR_BITS-1:`VTP_OFFSET_BITS];
        tlb_wr_pa <= out_pa_page;
    end

endmodule

/* vtp_shim.sv */
/*
 * Address translation shim for one memory request channel.
 * Hits and non-virtual requests leave 5 cycles after acceptance.
 * Only 4KB pages are translated.
 */

`timescale 1ns/1ns
`include "vtp_macros.svh"

module vtp_shim
(
    input  logic clk,
    input  logic reset,
    input  logic inval_tlb,
    input  logic req_valid,
    input  vtp_pkg::vtp_req_t req,
    output logic req_ready,
    output logic out_valid,
    output vtp_pkg::vtp_req_t out_req,
    input  logic out_almost_full,
    input  logic lookup_rdy,
    output logic lookup_en,
    output vtp_pkg::vtp_lookup_req_t lookup_req,
    input  logic lookup_rsp_valid,
    input  vtp_pkg::vtp_lookup_rsp_t lookup_rsp
);

    logic chan_out_valid;
    vtp_pkg::vtp_req_t chan_out_req;
    vtp_pkg::vtp_page_t chan_pa_page;

    vtp_chan chan_inst
    (
        .clk(clk),
        .reset(reset),
        .inval(inval_tlb),
        .not_full(req_ready),
        .in_valid(req_valid && req_ready),
        .in_req(req),
        .out_valid(chan_out_valid),
        .out_req(chan_out_req),
        .out_pa_page(chan_pa_page),
        .out_almost_full(out_almost_full),
        .lookup_rdy(lookup_rdy),
        .lookup_en(lookup_en),
        .lookup_req(lookup_req),
        .lookup_rsp_valid(lookup_rsp_valid),
        .lookup_rsp(lookup_rsp)
    );

    always_ff @(posedge clk)
    begin
        if (reset)
            out_valid <= 1'b0;
        else
            out_valid <= chan_out_valid;
    end

    // Page from the channel, line offset from the original address
    always_ff @(posedge clk)
    begin
        out_req <= chan_out_req;
        out_req.addr_is_virtual <= 1'b0;
        if (chan_out_req.addr_is_virtual)
            out_req.addr <= {chan_pa_page, chan_out_req.addr[`VTP_OFFSET_BITS-1:0]};
    end

endmodule

/* tb_vtp_assertions.sv */
/*
 * Concurrent checks bound into every vtp_chan instance.
 * fails counts failed assertions and is read by the testbench at the end.
 */

`timescale 1ns/1ns

module vtp_chan_assertions
(
    input logic clk,
    input logic reset,
    input logic in_valid,
    input logic in_virtual,
    input logic rsp_deq_q,
    input logic lookup_en,
    input logic out_valid
);

    int fails = 0;

    // Injected response only takes a stage 3 that no accepted request reached
    no_merge_collision: assert property (@(posedge clk) disable iff (reset)
        rsp_deq_q |-> !$past(in_valid, 3))
    else
    begin
        fails++;
        $error("main path and injected response completed in the same cycle");
    end

    // Lookup follows a virtual request accepted four cycles earlier
    lookup_only_virtual: assert property (@(posedge clk) disable iff (reset)
        lookup_en |-> $past(in_valid && in_virtual, 4))
    else
    begin
        fails++;
        $error("lookup issued for a request that is not virtual");
    end

    // Output stays quiet while the pipe empties out of reset
    quiet_after_reset: assert property (@(posedge clk)
        ($past(reset) || $past(reset, 2) || $past(reset, 3)) |-> !out_valid)
    else
    begin
        fails++;
        $error("output valid in the cycle after reset");
    end

endmodule

bind vtp_chan vtp_chan_assertions chan_checks
(
    .clk(clk),
    .reset(reset),
    .in_valid(in_valid),
    .in_virtual(in_req.addr_is_virtual),
    .rsp_deq_q(rsp_deq_q),
    .lookup_en(lookup_en),
    .out_valid(out_valid)
);

/* tb_vtp_shim.sv */
/*
 * Directed testbench for the translation shim.
 * Service model answers lookups in order, 1 to 8 cycles late, page = va XOR key.
 * The key only changes when nothing is in flight.
 */

`timescale 1ns/1ns
`include "vtp_macros.svh"

module tb_vtp_shim;

    localparam int TIMEOUT = 400;

    logic clk;
    logic reset;
    logic inval_tlb;
    logic req_valid;
    vtp_pkg::vtp_req_t req;
    logic req_ready;
    logic out_valid;
    vtp_pkg::vtp_req_t out_req;
    logic out_almost_full;
    logic lookup_rdy;
    logic lookup_en;
    vtp_pkg::vtp_lookup_req_t lookup_req;
    logic lookup_rsp_valid;
    vtp_pkg::vtp_lookup_rsp_t lookup_rsp;

    int cycle;
    int errors;
    int n_out;
    int n_lookup;
    int n_sent;
    logic [`VTP_MDATA_BITS-1:0] next_mdata;
    vtp_pkg::vtp_page_t map_key;
    vtp_pkg::vtp_page_t page_a;

    // Expected outputs by mdata, acceptance cycle for fixed-latency ones
    vtp_pkg::vtp_req_t exp_req [int];
    bit exp_fixed [int];
    int accept_at [int];

    // Lookups waiting for the service model
    vtp_pkg::vtp_lookup_req_t svc_q [$];
    int svc_due [$];

    vtp_shim vtp_shim_inst
    (
        .clk(clk),
        .reset(reset),
        .inval_tlb(inval_tlb),
        .req_valid(req_valid),
        .req(req),
        .req_ready(req_ready),
        .out_valid(out_valid),
        .out_req(out_req),
        .out_almost_full(out_almost_full),
        .lookup_rdy(lookup_rdy),
        .lookup_en(lookup_en),
        .lookup_req(lookup_req),
        .lookup_rsp_valid(lookup_rsp_valid),
        .lookup_rsp(lookup_rsp)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk)
        cycle <= cycle + 1;

    // ==============================
    // Compare tasks
    // ==============================

    task automatic check_req(input string name, input vtp_pkg::vtp_req_t got,
                             input vtp_pkg::vtp_req_t exp);
        if (got !== exp)
        begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp)
        begin
            $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    // ==============================
    // Service model and monitor
    // ==============================

    task automatic take_output();
        int key;
        key = out_req.mdata;
        n_out++;
        if (!exp_req.exists(key))
        begin
            $display("%0t: output with unexpected mdata %h", $time, out_req.mdata);
            errors++;
        end
        else
        begin
            check_req("out_req", out_req, exp_req[key]);
            // Hits and passthroughs have a fixed latency
            if (exp_fixed[key])
                check_count("latency", cycle - accept_at[key], 5);
            exp_req.delete(key);
        end
    endtask

    // Drive on the falling edge, sample 1 ns later while everything is stable
    always @(negedge clk)
    begin
        if (svc_q.size() != 0 && svc_due[0] <= cycle)
        begin
            lookup_rsp_valid = 1'b1;
            lookup_rsp.page_pa = svc_q[0].page_va ^ map_key;
            lookup_rsp.tag = svc_q[0].tag;
            void'(svc_q.pop_front());
            void'(svc_due.pop_front());
        end
        else
        begin
            lookup_rsp_valid = 1'b0;
        end
        #1;
        if (!reset)
        begin
            if (req_valid && req_ready)
                accept_at[req.mdata] = cycle;
            if (lookup_en)
            begin
                n_lookup++;
                svc_q.push_back(lookup_req);
                svc_due.push_back(cycle + 1 + $urandom_range(7));
            end
            if (out_valid)
                take_output();
        end
    end

    // ==============================
    // Stimulus helpers
    // ==============================

    // Random page with a chosen TLB index
    function automatic vtp_pkg::vtp_page_t rand_page(input logic [`VTP_CACHE_IDX_BITS-1:0] idx);
        vtp_pkg::vtp_page_t p;
        p = vtp_pkg::vtp_page_t'({$urandom(), $urandom()});
        p[`VTP_CACHE_IDX_BITS-1:0] = idx;
        return p;
    endfunction

    task automatic send(input bit virt, input vtp_pkg::vtp_page_t page, input bit fixed);
        vtp_pkg::vtp_req_t r;
        vtp_pkg::vtp_req_t e;
        logic [`VTP_OFFSET_BITS-1:0] off;
        int waited;
        off = $urandom_range((1 << `VTP_OFFSET_BITS) - 1);
        r.opcode = vtp_pkg::vtp_opcode_e'($urandom_range(1));
        r.addr_is_virtual = virt;
        r.addr = {page, off};
        r.mdata = next_mdata;
        // Expected form: physical page joined with the original offset
        e = r;
        e.addr_is_virtual = 1'b0;
        if (virt)
            e.addr = {page ^ map_key, off};
        next_mdata++;
        exp_req[r.mdata] = e;
        exp_fixed[r.mdata] = fixed;
        n_sent++;
        waited = 0;
        @(negedge clk);
        req_valid = 1'b1;
        req = r;
        #1;
        while (!req_ready && waited < TIMEOUT)
        begin
            @(negedge clk);
            #1;
            waited++;
        end
        if (!req_ready)
        begin
            $display("%0t: request %h was never accepted", $time, r.mdata);
            errors++;
        end
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic wait_ready(input logic level);
        int waited;
        waited = 0;
        @(negedge clk);
        #1;
        while (req_ready !== level && waited < TIMEOUT)
        begin
            @(negedge clk);
            #1;
            waited++;
        end
        if (req_ready !== level)
        begin
            $display("%0t: req_ready never went to %b", $time, level);
            errors++;
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while ((exp_req.size() != 0 || svc_q.size() != 0) && waited < TIMEOUT)
        begin
            @(negedge clk);
            waited++;
        end
        if (exp_req.size() != 0)
        begin
            $display("%0t: %0d requests never came out", $time, exp_req.size());
            errors++;
        end
        // Gap so the last refill lands in the TLB
        repeat (4) @(negedge clk);
    endtask

    task automatic report_test(input string name, input int errors_before);
        $display("%s: %0d errors", name, errors - errors_before);
    endtask

    // Holds one request while blocked, then releases the blocking input
    task automatic block_and_release(input bit use_almost_full);
        @(negedge clk);
        if (use_almost_full)
            out_almost_full = 1'b1;
        else
            lookup_rdy = 1'b0;
        repeat (2) @(negedge clk);
        fork
            send(1'b0, rand_page(4'h7), 1'b1);
            begin
                repeat (8)
                begin
                    @(negedge clk);
                    #1;
                    if (req_ready)
                    begin
                        $display("%0t: req_ready high while blocked", $time);
                        errors++;
                    end
                end
                @(negedge clk);
                out_almost_full = 1'b0;
                lookup_rdy = 1'b1;
            end
        join
    endtask

    // ==============================
    // Directed tests
    // ==============================

    task automatic test_passthrough();
        int e0;
        int l0;
        e0 = errors;
        l0 = n_lookup;
        send(1'b0, rand_page(4'h1), 1'b1);
        wait_drain();
        check_count("lookups", n_lookup - l0, 0);
        report_test("passthrough", e0);
    endtask

    task automatic test_first_miss();
        int e0;
        int l0;
        e0 = errors;
        l0 = n_lookup;
        page_a = rand_page(4'h3);
        send(1'b1, page_a, 1'b0);
        wait_drain();
        check_count("lookups", n_lookup - l0, 1);
        report_test("first miss", e0);
    endtask

    task automatic test_hit();
        int e0;
        int l0;
        e0 = errors;
        l0 = n_lookup;
        send(1'b1, page_a, 1'b1);
        wait_drain();
        check_count("lookups", n_lookup - l0, 0);
        // Hit behind a pending miss on another index
        send(1'b1, rand_page(4'h9), 1'b0);
        send(1'b1, page_a, 1'b1);
        wait_drain();
        check_count("lookups", n_lookup - l0, 1);
        report_test("hit", e0);
    endtask

    task automatic test_inval();
        int e0;
        int l0;
        e0 = errors;
        l0 = n_lookup;
        @(negedge clk);
        inval_tlb = 1'b1;
        map_key = rand_page(4'h0);
        @(negedge clk);
        inval_tlb = 1'b0;
        // Ready drops for the clear walk, then comes back
        wait_ready(1'b0);
        wait_ready(1'b1);
        send(1'b1, page_a, 1'b0);
        wait_drain();
        check_count("lookups", n_lookup - l0, 1);
        report_test("invalidate", e0);
    endtask

    task automatic test_backpressure();
        int e0;
        int l0;
        int o0;
        int s0;
        int nv;
        bit virt;
        e0 = errors;
        l0 = n_lookup;
        o0 = n_out;
        s0 = n_sent;
        nv = 0;
        block_and_release(1'b1);
        block_and_release(1'b0);
        for (int i = 0; i < 8; i++)
        begin
            virt = ($urandom_range(3) != 0);
            nv += virt;
            send(virt, rand_page(4'(i + 4)), !virt);
        end
        wait_drain();
        check_count("outputs", n_out - o0, n_sent - s0);
        check_count("lookups", n_lookup - l0, nv);
        report_test("backpressure", e0);
    endtask

    // ==============================
    // Main sequence
    // ==============================

    initial
    begin
        void'($urandom(32'hc99f));
        cycle = 0;
        errors = 0;
        n_out = 0;
        n_lookup = 0;
        n_sent = 0;
        next_mdata = '0;
        map_key = rand_page(4'h5);
        reset = 1'b1;
        inval_tlb = 1'b0;
        req_valid = 1'b0;
        req = '0;
        out_almost_full = 1'b0;
        lookup_rdy = 1'b1;
        lookup_rsp_valid = 1'b0;
        lookup_rsp = '0;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        // Initial TLB clear
        wait_ready(1'b1);
        test_passthrough();
        test_first_miss();
        test_hit();
        test_inval();
        test_backpressure();
        errors += vtp_shim_inst.chan_inst.chan_checks.fails;
        $display("sent %0d, outputs %0d, lookups %0d, errors %0d",
                 n_sent, n_out, n_lookup, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+.
vtp_pkg.sv
vtp_l1_tlb.sv
vtp_req_heap.sv
vtp_chan.sv
vtp_shim.sv
tb_vtp_assertions.sv
tb_vtp_shim.sv
